// File: include/trail_defines.svh
// ===========================================================================
// grid, tile and frame buffer size macros for the trail engine
// ===========================================================================
`ifndef TRAIL_DEFINES_SVH
`define TRAIL_DEFINES_SVH

// play field in cells
`define GRID_W 32
`define GRID_H 32
`define COORD_W 5

// frame buffer words per cell, and the row counter width
`define TILE_ROWS 4
`define ROW_W 2

// frame buffer port
`define FB_ADDR_W 12
`define FB_WORD_W 16
`define PIXEL_W 4

`endif

// File: rtl/trail_pkg.sv
// ===========================================================================
// game-side types: heading, player and trail kind
// ===========================================================================
package trail_pkg;

	// heading of a bike
	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_t;

	typedef enum logic {
		player_blue = 1'b0,
		player_red  = 1'b1
	} player_t;

	// trail classes written into the frame buffer
	typedef enum logic [2:0] {
		kind_none        = 3'd0,
		kind_blue_horiz  = 3'd1,
		kind_blue_vert   = 3'd2,
		kind_red_horiz   = 3'd3,
		kind_red_vert    = 3'd4,
		kind_corner      = 3'd5
	} trail_kind_t;

endpackage

// File: rtl/fb_pkg.sv
// ===========================================================================
// frame-buffer-side types: address, word and pixel values
// ===========================================================================
package fb_pkg;

	`include "trail_defines.svh"

	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;
	typedef logic [`FB_WORD_W-1:0] fb_word_t;

	// four of these make one frame buffer word
	typedef enum logic [`PIXEL_W-1:0] {
		pix_blank  = 4'd0,
		pix_blue   = 4'd1,
		pix_red    = 4'd3,
		pix_corner = 4'd5
	} pixel_t;

endpackage

// File: rtl/trail_decode.sv
// ===========================================================================
// trail decode: previous position latch, move detection, trail kind
// classification and the held job pair for the write sequencer
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_decode
	import trail_pkg::*;
(
	input  logic                Clk,
	input  logic                rst_n,
	input  logic                game_run,
	input  logic                tick,
	input  logic                job_take,
	input  logic [`COORD_W-1:0] blue_x,
	input  logic [`COORD_W-1:0] blue_y,
	input  logic [`COORD_W-1:0] red_x,
	input  logic [`COORD_W-1:0] red_y,
	input  dir_t                blue_dir,
	input  dir_t                red_dir,
	output logic                busy,
	output logic                move_strobe,
	output logic                blue_job_valid,
	output logic                red_job_valid,
	output logic                blue_moved,
	output logic                red_moved,
	output trail_kind_t         blue_kind,
	output trail_kind_t         red_kind,
	output logic [`COORD_W-1:0] blue_cell_x,
	output logic [`COORD_W-1:0] blue_cell_y,
	output logic [`COORD_W-1:0] red_cell_x,
	output logic [`COORD_W-1:0] red_cell_y,
	output logic [`COORD_W-1:0] blue_new_x,
	output logic [`COORD_W-1:0] blue_new_y,
	output logic [`COORD_W-1:0] red_new_x,
	output logic [`COORD_W-1:0] red_new_y
);

	logic                game_run_q;
	logic                start_round;
	logic                tick_ok;
	logic                blue_moves;
	logic                red_moves;
	logic [`COORD_W-1:0] last_blue_x;
	logic [`COORD_W-1:0] last_blue_y;
	logic [`COORD_W-1:0] last_red_x;
	logic [`COORD_W-1:0] last_red_y;
	dir_t                last_blue_dir;
	dir_t                last_red_dir;

	// corner on a turn, else by axis of travel
	function automatic trail_kind_t classify(player_t p, dir_t dir_now, dir_t dir_last);
		logic vertical;
		vertical = (dir_now == dir_up) || (dir_now == dir_down);
		if (dir_now != dir_last)
			return kind_corner;
		if (p == player_blue)
			return vertical ? kind_blue_vert : kind_blue_horiz;
		return vertical ? kind_red_vert : kind_red_horiz;
	endfunction

	assign busy        = blue_job_valid | red_job_valid;
	assign start_round = game_run & ~game_run_q;
	// first cycle of a round only latches, it makes no jobs
	assign tick_ok     = game_run & game_run_q & tick & ~busy;

	assign blue_moves = (blue_x != last_blue_x) || (blue_y != last_blue_y);
	assign red_moves  = (red_x != last_red_x) || (red_y != last_red_y);

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			game_run_q     <= 1'b0;
			move_strobe    <= 1'b0;
			blue_job_valid <= 1'b0;
			red_job_valid  <= 1'b0;
		end
		else
		begin
			game_run_q  <= game_run;
			move_strobe <= tick_ok;
			if (tick_ok)
			begin
				blue_job_valid <= 1'b1;
				red_job_valid  <= 1'b1;
			end
			else if (job_take)
			begin
				blue_job_valid <= 1'b0;
				red_job_valid  <= 1'b0;
			end
		end
	end

	// last position and heading per bike
	always_ff @(posedge Clk)
	begin
		if (start_round || tick_ok)
		begin
			last_blue_x   <= blue_x;
			last_blue_y   <= blue_y;
			last_red_x    <= red_x;
			last_red_y    <= red_y;
			last_blue_dir <= blue_dir;
			last_red_dir  <= red_dir;
		end
	end

	// job payload, held until the next accepted tick
	always_ff @(posedge Clk)
	begin
		if (tick_ok)
		begin
			blue_moved  <= blue_moves;
			red_moved   <= red_moves;
			blue_kind   <= blue_moves ? classify(player_blue, blue_dir, last_blue_dir) : kind_none;
			red_kind    <= red_moves ? classify(player_red, red_dir, last_red_dir) : kind_none;
			blue_cell_x <= last_blue_x;
			blue_cell_y <= last_blue_y;
			red_cell_x  <= last_red_x;
			red_cell_y  <= last_red_y;
			blue_new_x  <= blue_x;
			blue_new_y  <= blue_y;
			red_new_x   <= red_x;
			red_new_y   <= red_y;
		end
	end

endmodule

// File: rtl/trail_sprite_rom.sv
// ===========================================================================
// fixed sprite table, one frame buffer word per trail kind and row
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_sprite_rom
	import trail_pkg::*, fb_pkg::*;
(
	input  trail_kind_t       kind,
	input  logic [`ROW_W-1:0] row,
	output fb_word_t          word
);

	pixel_t color;

	// pixel color follows the owner of the trail
	always_comb
	begin
		case (kind)
			kind_blue_horiz, kind_blue_vert: color = pix_blue;
			kind_red_horiz, kind_red_vert:   color = pix_red;
			kind_corner:                     color = pix_corner;
			default:                         color = pix_blank;
		endcase
	end

	always_comb
	begin
		word = '0;
		case (kind)
			// two lit rows across the middle of the tile
			kind_blue_horiz, kind_red_horiz:
				if (row == 2'd1 || row == 2'd2)
					word = {4{color}};
			// two middle pixels on every row
			kind_blue_vert, kind_red_vert:
				word = {pix_blank, color, color, pix_blank};
			kind_corner:
				word = {4{color}};
			default:
				word = '0;
		endcase
	end

endmodule

// File: rtl/trail_execute.sv
// ===========================================================================
// trail execute: job sequencer writing sprite rows to the frame buffer
// over the four-phase req/ack port
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_execute
	import trail_pkg::*, fb_pkg::*;
(
	input  logic                Clk,
	input  logic                rst_n,
	input  logic                fb_ack,
	input  logic                blue_job_valid,
	input  logic                red_job_valid,
	input  trail_kind_t         blue_kind,
	input  trail_kind_t         red_kind,
	input  logic [`COORD_W-1:0] blue_cell_x,
	input  logic [`COORD_W-1:0] blue_cell_y,
	input  logic [`COORD_W-1:0] red_cell_x,
	input  logic [`COORD_W-1:0] red_cell_y,
	output logic                job_take,
	output logic                fb_req,
	output fb_addr_t            fb_addr,
	output fb_word_t            fb_data
);

	typedef enum logic [2:0] {
		st_idle,
		st_setup,
		st_request,
		st_release,
		st_advance
	} state_t;

	state_t              state;
	player_t             sel;
	logic [`ROW_W-1:0]   row;
	trail_kind_t         cur_kind;
	logic [`COORD_W-1:0] cur_x;
	logic [`COORD_W-1:0] cur_y;
	fb_word_t            rom_word;
	fb_addr_t            cell_addr;

	// job under service
	assign cur_kind = (sel == player_blue) ? blue_kind : red_kind;
	assign cur_x    = (sel == player_blue) ? blue_cell_x : red_cell_x;
	assign cur_y    = (sel == player_blue) ? blue_cell_y : red_cell_y;

	// (y * rows + row) * width + x
	assign cell_addr = fb_addr_t'((32'(cur_y) * `TILE_ROWS + 32'(row)) * `GRID_W + 32'(cur_x));

	trail_sprite_rom u_sprite_rom (
		.kind (cur_kind),
		.row  (row),
		.word (rom_word)
	);

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= st_idle;
			sel      <= player_blue;
			row      <= '0;
			fb_req   <= 1'b0;
			job_take <= 1'b0;
		end
		else
		begin
			job_take <= 1'b0;
			case (state)
				st_idle:
					// valids are still up in the cycle job_take is high
					if (blue_job_valid && red_job_valid && !job_take)
					begin
						sel   <= player_blue;
						row   <= '0;
						state <= st_setup;
					end
				st_setup:
					if (cur_kind == kind_none)
					begin
						if (sel == player_red)
						begin
							job_take <= 1'b1;
							state    <= st_idle;
						end
						else
						begin
							sel <= player_red;
							row <= '0;
						end
					end
					else
					begin
						fb_req <= 1'b1;
						state  <= st_request;
					end
				st_request:
					// a slow ack just holds here
					if (fb_ack)
					begin
						fb_req <= 1'b0;
						state  <= st_release;
					end
				st_release:
					if (!fb_ack)
						state <= st_advance;
				st_advance:
					if (row == 2'd3)
					begin
						if (sel == player_red)
						begin
							job_take <= 1'b1;
							state    <= st_idle;
						end
						else
						begin
							sel   <= player_red;
							row   <= '0;
							state <= st_setup;
						end
					end
					else
					begin
						row   <= row + 2'd1;
						state <= st_setup;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// address and data stay put for the whole handshake
	always_ff @(posedge Clk)
	begin
		if (state == st_setup)
		begin
			fb_addr <= cell_addr;
			fb_data <= rom_word;
		end
	end

endmodule

// File: rtl/trail_collision.sv
// ===========================================================================
// trail collision: occupancy bitmap of vacated cells and sticky crash flags
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_collision (
	input  logic                Clk,
	input  logic                rst_n,
	input  logic                game_run,
	input  logic                move_strobe,
	input  logic                blue_moved,
	input  logic                red_moved,
	input  logic [`COORD_W-1:0] blue_old_x,
	input  logic [`COORD_W-1:0] blue_old_y,
	input  logic [`COORD_W-1:0] red_old_x,
	input  logic [`COORD_W-1:0] red_old_y,
	input  logic [`COORD_W-1:0] blue_new_x,
	input  logic [`COORD_W-1:0] blue_new_y,
	input  logic [`COORD_W-1:0] red_new_x,
	input  logic [`COORD_W-1:0] red_new_y,
	output logic                blue_crash,
	output logic                red_crash
);

	logic [`GRID_W-1:0] occ [`GRID_H];
	logic               blue_hit;
	logic               red_hit;

	function automatic logic same_cell(logic [`COORD_W-1:0] ax, logic [`COORD_W-1:0] ay,
	                                   logic [`COORD_W-1:0] bx, logic [`COORD_W-1:0] by);
		return (ax == bx) && (ay == by);
	endfunction

	// old cells marked in this same update count as occupied
	assign blue_hit = occ[blue_new_y][blue_new_x]
		| (blue_moved & same_cell(blue_new_x, blue_new_y, blue_old_x, blue_old_y))
		| (red_moved & same_cell(blue_new_x, blue_new_y, red_old_x, red_old_y))
		| same_cell(blue_new_x, blue_new_y, red_new_x, red_new_y);

	assign red_hit = occ[red_new_y][red_new_x]
		| (red_moved & same_cell(red_new_x, red_new_y, red_old_x, red_old_y))
		| (blue_moved & same_cell(red_new_x, red_new_y, blue_old_x, blue_old_y))
		| same_cell(red_new_x, red_new_y, blue_new_x, blue_new_y);

	// map is wiped between rounds
	always_ff @(posedge Clk)
	begin
		if (!game_run)
		begin
			for (int y = 0; y < `GRID_H; y++)
				occ[y] <= '0;
		end
		else if (move_strobe)
		begin
			if (blue_moved)
				occ[blue_old_y][blue_old_x] <= 1'b1;
			if (red_moved)
				occ[red_old_y][red_old_x] <= 1'b1;
		end
	end

	// sticky until game_run falls
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else if (!game_run)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else if (move_strobe)
		begin
			blue_crash <= blue_crash | (blue_moved & blue_hit);
			red_crash  <= red_crash | (red_moved & red_hit);
		end
	end

endmodule

// File: rtl/trail_unit.sv
// ===========================================================================
// trail engine top: decode, execute and collision
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_unit
	import trail_pkg::*, fb_pkg::*;
(
	input  logic                Clk,
	input  logic                rst_n,
	input  logic                game_run,
	input  logic                tick,
	input  logic                fb_ack,
	input  logic [`COORD_W-1:0] blue_x,
	input  logic [`COORD_W-1:0] blue_y,
	input  logic [`COORD_W-1:0] red_x,
	input  logic [`COORD_W-1:0] red_y,
	input  dir_t                blue_dir,
	input  dir_t                red_dir,
	output logic                fb_req,
	output logic                busy,
	output logic                blue_crash,
	output logic                red_crash,
	output fb_addr_t            fb_addr,
	output fb_word_t            fb_data
);

	logic                job_take;
	logic                move_strobe;
	logic                blue_job_valid;
	logic                red_job_valid;
	logic                blue_moved;
	logic                red_moved;
	trail_kind_t         blue_kind;
	trail_kind_t         red_kind;
	logic [`COORD_W-1:0] blue_cell_x;
	logic [`COORD_W-1:0] blue_cell_y;
	logic [`COORD_W-1:0] red_cell_x;
	logic [`COORD_W-1:0] red_cell_y;
	logic [`COORD_W-1:0] blue_new_x;
	logic [`COORD_W-1:0] blue_new_y;
	logic [`COORD_W-1:0] red_new_x;
	logic [`COORD_W-1:0] red_new_y;

	trail_decode u_decode (
		.Clk            (Clk),
		.rst_n          (rst_n),
		.game_run       (game_run),
		.tick           (tick),
		.job_take       (job_take),
		.blue_x         (blue_x),
		.blue_y         (blue_y),
		.red_x          (red_x),
		.red_y          (red_y),
		.blue_dir       (blue_dir),
		.red_dir        (red_dir),
		.busy           (busy),
		.move_strobe    (move_strobe),
		.blue_job_valid (blue_job_valid),
		.red_job_valid  (red_job_valid),
		.blue_moved     (blue_moved),
		.red_moved      (red_moved),
		.blue_kind      (blue_kind),
		.red_kind       (red_kind),
		.blue_cell_x    (blue_cell_x),
		.blue_cell_y    (blue_cell_y),
		.red_cell_x     (red_cell_x),
		.red_cell_y     (red_cell_y),
		.blue_new_x     (blue_new_x),
		.blue_new_y     (blue_new_y),
		.red_new_x      (red_new_x),
		.red_new_y      (red_new_y)
	);

	trail_execute u_execute (
		.Clk            (Clk),
		.rst_n          (rst_n),
		.fb_ack         (fb_ack),
		.blue_job_valid (blue_job_valid),
		.red_job_valid  (red_job_valid),
		.blue_kind      (blue_kind),
		.red_kind       (red_kind),
		.blue_cell_x    (blue_cell_x),
		.blue_cell_y    (blue_cell_y),
		.red_cell_x     (red_cell_x),
		.red_cell_y     (red_cell_y),
		.job_take       (job_take),
		.fb_req         (fb_req),
		.fb_addr        (fb_addr),
		.fb_data        (fb_data)
	);

	// vacated cells from decode are the old cells for the map
	trail_collision u_collision (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.game_run    (game_run),
		.move_strobe (move_strobe),
		.blue_moved  (blue_moved),
		.red_moved   (red_moved),
		.blue_old_x  (blue_cell_x),
		.blue_old_y  (blue_cell_y),
		.red_old_x   (red_cell_x),
		.red_old_y   (red_cell_y),
		.blue_new_x  (blue_new_x),
		.blue_new_y  (blue_new_y),
		.red_new_x   (red_new_x),
		.red_new_y   (red_new_y),
		.blue_crash  (blue_crash),
		.red_crash   (red_crash)
	);

endmodule

// File: dv/trail_unit_asserts.sv
// ===========================================================================
// bound checks on the frame buffer handshake and reset state
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_unit_asserts (
	input logic                  Clk,
	input logic                  rst_n,
	input logic                  fb_req,
	input logic                  fb_ack,
	input logic                  job_take,
	input logic [`FB_ADDR_W-1:0] fb_addr,
	input logic [`FB_WORD_W-1:0] fb_data
);

	// address and data hold until the memory answers
	req_holds_payload: assert property (@(posedge Clk) disable iff (!rst_n)
		(fb_req && !fb_ack) |=> ($stable(fb_addr) && $stable(fb_data)))
		else $error("fb_addr or fb_data changed during a pending request");

	// a new request waits for ack to drop
	req_waits_for_ack_low: assert property (@(posedge Clk) disable iff (!rst_n)
		$rose(fb_req) |-> !$past(fb_ack))
		else $error("fb_req rose while fb_ack was still high");

	reset_outputs_low: assert property (@(posedge Clk)
		$rose(rst_n) |-> (!fb_req && !job_take))
		else $error("fb_req or job_take high coming out of reset");

endmodule

// File: dv/trail_unit_checker.sv
// ===========================================================================
// watches frame buffer writes and crash flags and compares them per entry
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_unit_checker
	import trail_pkg::*, fb_pkg::*;
(
	input  logic                Clk,
	input  logic                rst_n,
	input  logic                fb_req,
	input  logic                fb_ack,
	input  fb_addr_t            fb_addr,
	input  fb_word_t            fb_data,
	input  logic                blue_crash,
	input  logic                red_crash,
	input  logic                check_en,
	input  logic                report_en,
	input  int                  entry_idx,
	input  trail_kind_t         exp_blue_kind,
	input  trail_kind_t         exp_red_kind,
	input  logic [`COORD_W-1:0] blue_old_x,
	input  logic [`COORD_W-1:0] blue_old_y,
	input  logic [`COORD_W-1:0] red_old_x,
	input  logic [`COORD_W-1:0] red_old_y,
	input  logic                exp_blue_crash,
	input  logic                exp_red_crash,
	output int                  error_count
);

	fb_addr_t got_addr[$];
	fb_word_t got_data[$];
	fb_addr_t exp_addr[$];
	fb_word_t exp_data[$];
	logic     ack_q;
	int       tests_run;
	int       tests_failed;
	int       total_errors;

	assign error_count = total_errors;

	// expected sprite word for a kind and row
	function automatic fb_word_t sprite_word(trail_kind_t k, int row);
		logic [3:0] c;
		c = 4'd0;
		if (k == kind_blue_horiz || k == kind_blue_vert)
			c = 4'd1;
		else if (k == kind_red_horiz || k == kind_red_vert)
			c = 4'd3;
		else if (k == kind_corner)
			c = 4'd5;
		if (k == kind_blue_horiz || k == kind_red_horiz)
			return (row == 1 || row == 2) ? {c, c, c, c} : 16'h0000;
		if (k == kind_blue_vert || k == kind_red_vert)
			return {4'd0, c, c, 4'd0};
		return {c, c, c, c};
	endfunction

	function automatic fb_addr_t cell_addr(logic [`COORD_W-1:0] x, logic [`COORD_W-1:0] y,
	                                       int row);
		int a;
		a = (int'(y) * `TILE_ROWS + row) * `GRID_W + int'(x);
		return fb_addr_t'(a);
	endfunction

	task automatic add_job(trail_kind_t k, logic [`COORD_W-1:0] x, logic [`COORD_W-1:0] y);
		if (k != kind_none)
		begin
			for (int r = 0; r < `TILE_ROWS; r++)
			begin
				exp_addr.push_back(cell_addr(x, y, r));
				exp_data.push_back(sprite_word(k, r));
			end
		end
	endtask

	task automatic check_entry();
		int errs;
		int n;
		errs = 0;
		exp_addr.delete();
		exp_data.delete();
		// blue rows first, then red
		add_job(exp_blue_kind, blue_old_x, blue_old_y);
		add_job(exp_red_kind, red_old_x, red_old_y);
		n = (exp_addr.size() < got_addr.size()) ? exp_addr.size() : got_addr.size();
		for (int i = 0; i < n; i++)
		begin
			if (got_addr[i] !== exp_addr[i])
			begin
				$display("[ERROR] t=%0t fb_addr expected %h got %h", $time,
					exp_addr[i], got_addr[i]);
				errs++;
			end
			if (got_data[i] !== exp_data[i])
			begin
				$display("[ERROR] t=%0t fb_data expected %h got %h", $time,
					exp_data[i], got_data[i]);
				errs++;
			end
		end
		if (got_addr.size() != exp_addr.size())
		begin
			$display("entry %0d: expected %0d frame buffer writes but saw %0d", entry_idx,
				exp_addr.size(), got_addr.size());
			errs++;
		end
		if (blue_crash !== exp_blue_crash)
		begin
			$display("[ERROR] t=%0t blue_crash expected %b got %b", $time,
				exp_blue_crash, blue_crash);
			errs++;
		end
		if (red_crash !== exp_red_crash)
		begin
			$display("[ERROR] t=%0t red_crash expected %b got %b", $time,
				exp_red_crash, red_crash);
			errs++;
		end
		tests_run++;
		if (errs != 0)
			tests_failed++;
		total_errors += errs;
		$display("entry %0d: %0d writes, %s", entry_idx, got_addr.size(),
			(errs == 0) ? "ok" : "mismatch");
		got_addr.delete();
		got_data.delete();
	endtask

	initial
	begin
		tests_run = 0;
		tests_failed = 0;
		total_errors = 0;
		ack_q = 1'b0;
	end

	always @(posedge Clk)
	begin
		// one write per ack rise
		if (rst_n && fb_req && fb_ack && !ack_q)
		begin
			got_addr.push_back(fb_addr);
			got_data.push_back(fb_data);
		end
		ack_q = fb_ack;
		if (check_en)
			check_entry();
		if (report_en)
			$display("entries run %0d, failed %0d, errors %0d", tests_run, tests_failed,
				total_errors);
	end

endmodule

// File: dv/trail_unit_tb.sv
// ===========================================================================
// trail engine testbench with clock, reset, tick table and frame buffer
// responder
// ===========================================================================
`timescale 1ns/100ps

`include "trail_defines.svh"

module trail_unit_tb;
	import trail_pkg::*, fb_pkg::*;

	localparam int NUM_ENTRIES = 12;
	// setup, up to four cycles waiting for ack, release and advance
	localparam int CYCLES_PER_WRITE = 8;
	// two jobs of four rows, plus tick, job take and round start
	localparam int CYCLES_PER_ENTRY = 2 * `TILE_ROWS * CYCLES_PER_WRITE + 16;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * CYCLES_PER_ENTRY + 10;
	localparam logic [1:0] OP_START = 2'd1;
	localparam logic [1:0] OP_BUSY = 2'd2;

	logic Clk;
	logic rst_n;
	logic game_run;
	logic tick;
	logic fb_ack;
	logic [`COORD_W-1:0] blue_x;
	logic [`COORD_W-1:0] blue_y;
	logic [`COORD_W-1:0] red_x;
	logic [`COORD_W-1:0] red_y;
	dir_t blue_dir;
	dir_t red_dir;
	logic fb_req;
	logic busy;
	logic blue_crash;
	logic red_crash;
	fb_addr_t fb_addr;
	fb_word_t fb_data;

	// checker side
	logic check_en;
	logic report_en;
	int entry_idx;
	int error_count;
	int cycles;
	trail_kind_t exp_blue_kind;
	trail_kind_t exp_red_kind;
	logic exp_blue_crash;
	logic exp_red_crash;
	logic [`COORD_W-1:0] old_bx;
	logic [`COORD_W-1:0] old_by;
	logic [`COORD_W-1:0] old_rx;
	logic [`COORD_W-1:0] old_ry;

	// tick table of op, positions, heads, expected kinds and crash flags
	logic [1:0] t_op [NUM_ENTRIES];
	logic [`COORD_W-1:0] t_bx [NUM_ENTRIES];
	logic [`COORD_W-1:0] t_by [NUM_ENTRIES];
	logic [`COORD_W-1:0] t_rx [NUM_ENTRIES];
	logic [`COORD_W-1:0] t_ry [NUM_ENTRIES];
	dir_t t_bd [NUM_ENTRIES];
	dir_t t_rd [NUM_ENTRIES];
	trail_kind_t t_bk [NUM_ENTRIES];
	trail_kind_t t_rk [NUM_ENTRIES];
	logic t_bc [NUM_ENTRIES];
	logic t_rc [NUM_ENTRIES];

	// responder state
	logic [16:0] lfsr;
	logic [1:0] ack_wait;
	logic pending;

	trail_unit UUT (.Clk(Clk), .rst_n(rst_n), .game_run(game_run), .tick(tick), .fb_ack(fb_ack),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir), .fb_req(fb_req), .busy(busy),
		.blue_crash(blue_crash), .red_crash(red_crash), .fb_addr(fb_addr), .fb_data(fb_data));

	trail_unit_checker u_checker (.Clk(Clk), .rst_n(rst_n), .fb_req(fb_req), .fb_ack(fb_ack),
		.fb_addr(fb_addr), .fb_data(fb_data), .blue_crash(blue_crash), .red_crash(red_crash),
		.check_en(check_en), .report_en(report_en), .entry_idx(entry_idx),
		.exp_blue_kind(exp_blue_kind), .exp_red_kind(exp_red_kind),
		.blue_old_x(old_bx), .blue_old_y(old_by), .red_old_x(old_rx), .red_old_y(old_ry),
		.exp_blue_crash(exp_blue_crash), .exp_red_crash(exp_red_crash),
		.error_count(error_count));

	bind trail_execute trail_unit_asserts u_asserts (.Clk(Clk), .rst_n(rst_n), .fb_req(fb_req),
		.fb_ack(fb_ack), .job_take(job_take), .fb_addr(fb_addr), .fb_data(fb_data));

	always #50 Clk = ~Clk;

	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsr_next(logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic add_entry(int i, logic [1:0] op, int bx, int by, dir_t bd, int rx, int ry,
	                         dir_t rd, trail_kind_t bk, trail_kind_t rk, logic bc, logic rc);
		t_op[i] = op;
		t_bx[i] = bx[`COORD_W-1:0];
		t_by[i] = by[`COORD_W-1:0];
		t_rx[i] = rx[`COORD_W-1:0];
		t_ry[i] = ry[`COORD_W-1:0];
		t_bd[i] = bd;
		t_rd[i] = rd;
		t_bk[i] = bk;
		t_rk[i] = rk;
		t_bc[i] = bc;
		t_rc[i] = rc;
	endtask

	task automatic drive_positions(int i);
		blue_x = t_bx[i];
		blue_y = t_by[i];
		red_x = t_rx[i];
		red_y = t_ry[i];
		blue_dir = t_bd[i];
		red_dir = t_rd[i];
	endtask

	task automatic apply_entry(int i);
		if (t_op[i] == OP_START)
		begin
			@(negedge Clk);
			game_run = 1'b0;
			repeat (3) @(negedge Clk);
			drive_positions(i);
			game_run = 1'b1;
			repeat (3) @(negedge Clk);
		end
		else
		begin
			@(negedge Clk);
			drive_positions(i);
			tick = 1'b1;
			@(negedge Clk);
			tick = 1'b0;
			if (t_op[i] == OP_BUSY)
			begin
				// a tick with far-off positions while the job is still pending
				blue_x = 5'd31;
				blue_y = 5'd31;
				red_x = 5'd30;
				red_y = 5'd30;
				tick = 1'b1;
				@(negedge Clk);
				tick = 1'b0;
				drive_positions(i);
			end
			while (busy)
				@(negedge Clk);
		end
		// old cells are the positions latched on the previous entry
		entry_idx = i;
		exp_blue_kind = t_bk[i];
		exp_red_kind = t_rk[i];
		exp_blue_crash = t_bc[i];
		exp_red_crash = t_rc[i];
		check_en = 1'b1;
		@(negedge Clk);
		check_en = 1'b0;
		old_bx = t_bx[i];
		old_by = t_by[i];
		old_rx = t_rx[i];
		old_ry = t_ry[i];
	endtask

	// frame buffer responder with random ack delay
	always @(negedge Clk)
	begin
		if (!rst_n)
		begin
			fb_ack = 1'b0;
			pending = 1'b0;
		end
		else if (fb_req && !fb_ack)
		begin
			if (!pending)
			begin
				ack_wait[0] = lfsr[16];
				lfsr = lfsr_next(lfsr);
				ack_wait[1] = lfsr[16];
				lfsr = lfsr_next(lfsr);
				pending = 1'b1;
			end
			if (ack_wait == 2'd0)
			begin
				fb_ack = 1'b1;
				pending = 1'b0;
			end
			else
				ack_wait = ack_wait - 2'd1;
		end
		else if (!fb_req && fb_ack)
			fb_ack = 1'b0;
	end

	always @(posedge Clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run exceeded %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		Clk = 1'b0;
		rst_n = 1'b0;
		game_run = 1'b0;
		tick = 1'b0;
		fb_ack = 1'b0;
		pending = 1'b0;
		ack_wait = 2'd0;
		lfsr = 17'd83519;
		cycles = 0;
		check_en = 1'b0;
		report_en = 1'b0;
		entry_idx = 0;
		exp_blue_kind = kind_none;
		exp_red_kind = kind_none;
		exp_blue_crash = 1'b0;
		exp_red_crash = 1'b0;
		blue_x = '0;
		blue_y = '0;
		red_x = '0;
		red_y = '0;
		blue_dir = dir_up;
		red_dir = dir_up;
		old_bx = '0;
		old_by = '0;
		old_rx = '0;
		old_ry = '0;
		add_entry(0, OP_START, 2, 5, dir_right, 20, 10, dir_left,
			kind_none, kind_none, 0, 0);
		add_entry(1, 2'd0, 3, 5, dir_right, 19, 10, dir_left,
			kind_blue_horiz, kind_red_horiz, 0, 0);
		add_entry(2, 2'd0, 3, 6, dir_down, 19, 10, dir_left,
			kind_corner, kind_none, 0, 0);
		add_entry(3, 2'd0, 3, 7, dir_down, 19, 9, dir_up,
			kind_blue_vert, kind_corner, 0, 0);
		add_entry(4, OP_BUSY, 3, 8, dir_down, 19, 8, dir_up,
			kind_blue_vert, kind_red_vert, 0, 0);
		add_entry(5, 2'd0, 3, 9, dir_down, 19, 7, dir_up,
			kind_blue_vert, kind_red_vert, 0, 0);
		// blue turns back into its own trail
		add_entry(6, 2'd0, 3, 8, dir_up, 19, 6, dir_up,
			kind_corner, kind_red_vert, 1, 0);
		// flag holds while blue moves on to a free cell
		add_entry(7, 2'd0, 2, 8, dir_left, 19, 5, dir_up,
			kind_corner, kind_red_vert, 1, 0);
		add_entry(8, OP_START, 10, 10, dir_right, 12, 10, dir_left,
			kind_none, kind_none, 0, 0);
		add_entry(9, 2'd0, 11, 10, dir_right, 11, 10, dir_left,
			kind_blue_horiz, kind_red_horiz, 1, 1);
		add_entry(10, OP_START, 2, 5, dir_right, 20, 10, dir_left,
			kind_none, kind_none, 0, 0);
		add_entry(11, 2'd0, 3, 5, dir_right, 19, 10, dir_left,
			kind_blue_horiz, kind_red_horiz, 0, 0);
		repeat (10) @(negedge Clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++)
			apply_entry(i);
		report_en = 1'b1;
		@(negedge Clk);
		report_en = 1'b0;
		@(negedge Clk);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: trail_unit.f
+incdir+include
rtl/trail_pkg.sv
rtl/fb_pkg.sv
rtl/trail_decode.sv
rtl/trail_sprite_rom.sv
rtl/trail_execute.sv
rtl/trail_collision.sv
rtl/trail_unit.sv
dv/trail_unit_asserts.sv
dv/trail_unit_checker.sv
dv/trail_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = trail_unit_tb
FILELIST  = trail_unit.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
